// File: include/queue_cfg.svh
`ifndef QUEUE_CFG_SVH
`define QUEUE_CFG_SVH

// Bits in one byte of a request word.
`define BYTE_LEN_IN_BITS 8

// Width of one request word, address and payload together.
`define REQUEST_WIDTH 64

// Entries in each request queue.
// This must be a power of two so the pointers wrap on their own.
`define QUEUE_SIZE 8

// Number of queues that feed the arbiter.
`define NUM_SOURCES 2

`endif

// File: hdl/request_pkg.sv
`include "queue_cfg.svh"

package request_pkg;

    localparam int addr_width = 32;

    // the address sits in the upper half of the word.
    typedef struct packed {
        logic [addr_width-1:0]                addr;
        logic [`REQUEST_WIDTH-addr_width-1:0] payload;
    } request_t;

    // one write enable per byte of a request word.
    typedef logic [`REQUEST_WIDTH/`BYTE_LEN_IN_BITS-1:0] mask_t;

endpackage

// File: hdl/arbiter_pkg.sv
`include "queue_cfg.svh"

package arbiter_pkg;

    // number of the queue a request came from.
    typedef logic [$clog2(`NUM_SOURCES)-1:0] source_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_issue,
        arb_release
    } arb_state_t;

endpackage

// File: hdl/dual_port_lutram.sv
`timescale 1ns/1ps
`include "queue_cfg.svh"

module dual_port_lutram
#(
    parameter int num_set     = `QUEUE_SIZE,
    parameter     config_mode = "WriteFirst"
)
(
    input  logic                       clk_in,
    input  logic                       reset_in,
    input  request_pkg::mask_t         write_en,
    input  logic [$clog2(num_set)-1:0] write_addr,
    input  request_pkg::request_t      write_data,
    input  logic [$clog2(num_set)-1:0] read_addr,
    output request_pkg::request_t      read_data
);
    import request_pkg::*;

    localparam int byte_w    = `BYTE_LEN_IN_BITS;
    localparam int num_bytes = $bits(mask_t);

    request_t ram [num_set];

    always_ff @(posedge clk_in)
    begin
        if (!reset_in)  // nothing is stored while the queue is held in reset.
        begin
            for (int b = 0; b < num_bytes; b++)
            begin
                if (write_en[b])
                begin
                    ram[write_addr][b*byte_w +: byte_w] <= write_data[b*byte_w +: byte_w];
                end
            end
        end
    end

    always_comb
    begin
        read_data = ram[read_addr];
        if (config_mode == "WriteFirst" && write_addr == read_addr)
        begin
            for (int b = 0; b < num_bytes; b++)
            begin
                if (write_en[b])
                begin
                    read_data[b*byte_w +: byte_w] = write_data[b*byte_w +: byte_w];  // new byte wins.
                end
            end
        end
    end

endmodule

// File: hdl/fifo_queue.sv
`timescale 1ns/1ps
`include "queue_cfg.svh"

module fifo_queue
#(
    parameter storage_type = "FlipFlop"
)
(
    input  logic                  clk_in,
    input  logic                  reset_in,

    output logic                  is_empty_out,
    output logic                  is_full_out,

    input  request_pkg::request_t request_in,
    input  logic                  request_valid_in,
    output logic                  issue_ack_out,

    output request_pkg::request_t request_out,
    output logic                  request_valid_out,
    input  logic                  issue_ack_in
);
    import request_pkg::*;

    localparam int ptr_w = $clog2(`QUEUE_SIZE);

    logic [`QUEUE_SIZE-1:0] valid_bits;
    logic [ptr_w-1:0]       write_ptr;
    logic [ptr_w-1:0]       read_ptr;
    logic                   write_ok;
    logic                   read_done;
    logic                   bypass;
    request_t               head_entry;

    assign is_full_out  = &valid_bits;
    assign is_empty_out = ~|valid_bits;

    assign read_done = issue_ack_in & valid_bits[read_ptr];
    // when full the write slot is the head, so a release frees it in the same cycle.
    assign write_ok  = request_valid_in & ~issue_ack_out & (~is_full_out | read_done);
    assign bypass    = write_ok & ~valid_bits[read_ptr] & (write_ptr == read_ptr);

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            write_ptr     <= '0;
            read_ptr      <= '0;
            valid_bits    <= '0;
            issue_ack_out <= 1'b0;
        end
        else
        begin
            issue_ack_out <= write_ok;  // the ack follows the accepted write by one cycle.
            if (read_done)
            begin
                read_ptr             <= read_ptr + 1'b1;
                valid_bits[read_ptr] <= 1'b0;
            end
            if (write_ok)
            begin
                write_ptr             <= write_ptr + 1'b1;
                valid_bits[write_ptr] <= 1'b1;  // overrides the clear when both hit one slot.
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            request_valid_out <= 1'b0;
        end
        else if (read_done)
        begin
            request_valid_out <= 1'b0;  // the output rests for one cycle after each ack.
        end
        else
        begin
            request_valid_out <= valid_bits[read_ptr] | bypass;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (!read_done && valid_bits[read_ptr])
        begin
            request_out <= head_entry;
        end
        else if (!read_done && bypass)
        begin
            request_out <= request_in;  // an empty queue hands the write straight through.
        end
    end

    if (storage_type == "LUTRAM")
    begin : g_lutram
        mask_t ram_write_en;

        assign ram_write_en = write_ok ? '1 : '0;

        dual_port_lutram
        #(
            .num_set     (`QUEUE_SIZE),
            .config_mode ("WriteFirst")
        )
        u_ram
        (
            .clk_in      (clk_in),
            .reset_in    (reset_in),
            .write_en    (ram_write_en),
            .write_addr  (write_ptr),
            .write_data  (request_in),
            .read_addr   (read_ptr),
            .read_data   (head_entry)
        );
    end
    else
    begin : g_flipflop
        request_t entries [`QUEUE_SIZE];

        always_ff @(posedge clk_in)
        begin
            if (write_ok)
            begin
                entries[write_ptr] <= request_in;
            end
        end

        assign head_entry = entries[read_ptr];
    end

    // an occupied slot only takes a write when it is the head and leaves in the same cycle.
    full_blocks_write: assert property (@(posedge clk_in) disable iff (reset_in)
        write_ok && valid_bits[write_ptr] |-> read_done && (write_ptr == read_ptr));

    out_held: assert property (@(posedge clk_in) disable iff (reset_in)
        request_valid_out && !issue_ack_in |=> request_valid_out && $stable(request_out));

endmodule

// File: hdl/request_arbiter.sv
`timescale 1ns/1ps
`include "queue_cfg.svh"

module request_arbiter
(
    input  logic                    clk_in,
    input  logic                    reset_in,

    input  request_pkg::request_t   source_request [`NUM_SOURCES],
    input  logic [`NUM_SOURCES-1:0] source_valid,
    output logic [`NUM_SOURCES-1:0] source_ack,

    output request_pkg::request_t   out_request,
    output arbiter_pkg::source_t    out_source,
    output logic                    out_valid,
    input  logic                    out_ack
);
    import arbiter_pkg::*;

    arb_state_t state;
    source_t    last_served;
    source_t    pick;
    logic       pick_found;

    // search starts at the source after the one served last.
    always_comb
    begin
        int cand;
        pick       = last_served;
        pick_found = 1'b0;
        for (int i = 1; i <= `NUM_SOURCES; i++)
        begin
            cand = (int'(last_served) + i) % `NUM_SOURCES;
            if (!pick_found && source_valid[cand])
            begin
                pick       = source_t'(cand);
                pick_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            state       <= arb_idle;
            last_served <= source_t'(`NUM_SOURCES - 1);  // source 0 wins the first tie.
        end
        else
        begin
            case (state)
                arb_idle:
                begin
                    if (pick_found)
                    begin
                        state <= arb_issue;
                    end
                end
                arb_issue:
                begin
                    if (out_ack)
                    begin
                        state       <= arb_release;
                        last_served <= out_source;
                    end
                end
                arb_release:
                begin
                    state <= arb_idle;  // the queue's valid is stale here and must be skipped.
                end
                default:
                begin
                    state <= arb_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (state == arb_idle && pick_found)
        begin
            out_request <= source_request[pick];
            out_source  <= pick;
        end
    end

    assign out_valid = (state == arb_issue);

    always_comb
    begin
        source_ack = '0;
        if (state == arb_release)
        begin
            source_ack[out_source] = 1'b1;
        end
    end

    // only a queue that still shows its word can be released.
    ack_onehot: assert property (@(posedge clk_in) disable iff (reset_in)
        $onehot0(source_ack) && ((source_ack & ~source_valid) == '0));

    out_held: assert property (@(posedge clk_in) disable iff (reset_in)
        out_valid && !out_ack |=> out_valid && $stable(out_request) && $stable(out_source));

    // the released queue has dropped its valid by the time the arbiter is idle again.
    no_double_grant: assert property (@(posedge clk_in) disable iff (reset_in)
        |source_ack |=> (source_valid & $past(source_ack)) == '0);

endmodule

// File: hdl/request_merge_top.sv
`timescale 1ns/1ps
`include "queue_cfg.svh"

module request_merge_top
(
    input  logic                  clk_in,
    input  logic                  reset_in,

    input  request_pkg::request_t req0,
    input  logic                  req0_valid,
    output logic                  req0_ack,

    input  request_pkg::request_t req1,
    input  logic                  req1_valid,
    output logic                  req1_ack,

    output request_pkg::request_t out_request,
    output arbiter_pkg::source_t  out_source,
    output logic                  out_valid,
    input  logic                  out_ack
);
    import request_pkg::*;

    request_t                queue_request [`NUM_SOURCES];
    logic [`NUM_SOURCES-1:0] queue_valid;
    logic [`NUM_SOURCES-1:0] queue_ack;

    fifo_queue #(.storage_type("FlipFlop")) u_queue0
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .is_empty_out      (),
        .is_full_out       (),
        .request_in        (req0),
        .request_valid_in  (req0_valid),
        .issue_ack_out     (req0_ack),
        .request_out       (queue_request[0]),
        .request_valid_out (queue_valid[0]),
        .issue_ack_in      (queue_ack[0])
    );

    fifo_queue #(.storage_type("LUTRAM")) u_queue1
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .is_empty_out      (),
        .is_full_out       (),
        .request_in        (req1),
        .request_valid_in  (req1_valid),
        .issue_ack_out     (req1_ack),
        .request_out       (queue_request[1]),
        .request_valid_out (queue_valid[1]),
        .issue_ack_in      (queue_ack[1])
    );

    request_arbiter u_arbiter
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .source_request    (queue_request),
        .source_valid      (queue_valid),
        .source_ack        (queue_ack),
        .out_request       (out_request),
        .out_source        (out_source),
        .out_valid         (out_valid),
        .out_ack           (out_ack)
    );

endmodule

// File: testbench/tb_request_merge.sv
`timescale 1ns/1ps
`include "queue_cfg.svh"

module tb_request_merge;
    import request_pkg::*;
    import arbiter_pkg::*;

    localparam int per_request_cycles = 40;
    localparam int stall_cycles       = 4 * `QUEUE_SIZE + 10;

    logic     clk_in;
    logic     reset_in;
    request_t req0;
    logic     req0_valid;
    logic     req0_ack;
    request_t req1;
    logic     req1_valid;
    logic     req1_ack;
    request_t out_request;
    source_t  out_source;
    logic     out_valid;
    logic     out_ack;

    request_t expected0 [$];
    request_t expected1 [$];
    int       ack_mode;  // 0 is random, 1 holds out_ack low, 2 holds it high.
    logic     fair_check;
    logic     served_any;
    source_t  last_src;
    logic     held_prev;
    request_t prev_request;
    source_t  prev_source;
    logic     stall_sent;
    int       cycle_limit = 0;

    request_merge_top uut
    (
        .clk_in      (clk_in),
        .reset_in    (reset_in),
        .req0        (req0),
        .req0_valid  (req0_valid),
        .req0_ack    (req0_ack),
        .req1        (req1),
        .req1_valid  (req1_valid),
        .req1_ack    (req1_ack),
        .out_request (out_request),
        .out_source  (out_source),
        .out_valid   (out_valid),
        .out_ack     (out_ack)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    task automatic mismatch_error(input string name, input logic [63:0] got,
                                  input logic [63:0] want);
        $display("** Error at %0t: %s = %h, expected %h", $time, name, got, want);
        $display("Simulation finished: FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic stop_with_failure(input string what);
        $display("%s (time %0t)", what, $time);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic next_cycle();
        @(posedge clk_in);
        #1;  // outputs have settled and inputs change here.
    endtask

    function automatic logic ack_seen(input int src);
        return (src == 0) ? req0_ack : req1_ack;
    endfunction

    task automatic present(input int src, input request_t word, input logic valid);
        if (src == 0)
        begin
            req0       = word;
            req0_valid = valid;
        end
        else
        begin
            req1       = word;
            req1_valid = valid;
        end
    endtask

    task automatic push_expected(input int src, input request_t word);
        int depth;
        depth = (src == 0) ? expected0.size() : expected1.size();
        assert (depth < `QUEUE_SIZE)
        else stop_with_failure("A requester got an ack while its queue was already full.");
        if (src == 0)
        begin
            expected0.push_back(word);
        end
        else
        begin
            expected1.push_back(word);
        end
    endtask

    task automatic send_words(input int src, input int count, input int max_gap);
        request_t word;
        int       gap;
        for (int n = 0; n < count; n++)
        begin
            word = {$urandom, $urandom};
            present(src, word, 1'b1);
            do
            begin
                next_cycle();
            end
            while (!ack_seen(src));
            push_expected(src, word);  // the word counts as queued once its ack is seen.
            gap = $urandom_range(max_gap, 0);
            if (gap > 0 || n == count - 1)
            begin
                present(src, word, 1'b0);
            end
            repeat (gap) next_cycle();
        end
    endtask

    task automatic downstream_step();
        request_t head;
        int       depth;
        logic     ack;
        if (held_prev)
        begin
            assert (out_valid) else stop_with_failure("out_valid dropped before out_ack.");
            assert (out_request == prev_request)
            else mismatch_error("out_request", out_request, prev_request);
            assert (out_source == prev_source)
            else mismatch_error("out_source", 64'(out_source), 64'(prev_source));
        end
        if (out_valid)
        begin
            depth = (out_source == 1'b0) ? expected0.size() : expected1.size();
            assert (depth > 0)
            else stop_with_failure("out_valid is high with no word pending from that source.");
            head = (out_source == 1'b0) ? expected0[0] : expected1[0];
            assert (out_request == head) else mismatch_error("out_request", out_request, head);
        end
        ack     = (ack_mode == 2) || (ack_mode == 0 && $urandom_range(3, 0) != 0);
        out_ack = ack;
        if (out_valid && ack)
        begin
            if (fair_check && served_any)
            begin
                assert (out_source != last_src)
                else mismatch_error("out_source", 64'(out_source), 64'(~last_src));
            end
            served_any = 1'b1;
            last_src   = out_source;
            if (out_source == 1'b0)
            begin
                void'(expected0.pop_front());
            end
            else
            begin
                void'(expected1.pop_front());
            end
        end
        held_prev    = out_valid && !ack;
        prev_request = out_request;
        prev_source  = out_source;
    endtask

    task automatic wait_drained();
        while (expected0.size() != 0 || expected1.size() != 0)
        begin
            next_cycle();
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles)
        begin
            next_cycle();
            assert (!out_valid) else stop_with_failure("out_valid rose with no request left.");
        end
    endtask

    initial
    begin
        forever
        begin
            next_cycle();
            if (!reset_in)
            begin
                downstream_step();
            end
        end
    end

    initial
    begin
        wait (cycle_limit != 0);
        repeat (cycle_limit) @(posedge clk_in);
        stop_with_failure($sformatf("Timeout: the run did not end within %0d cycles.",
                                    cycle_limit));
    end

    initial
    begin
        int n0;
        int n1;
        void'($urandom(32'h134be3d3));
        reset_in   = 1'b1;
        req0       = '0;
        req0_valid = 1'b0;
        req1       = '0;
        req1_valid = 1'b0;
        out_ack    = 1'b0;
        ack_mode   = 0;
        fair_check = 1'b0;
        served_any = 1'b0;
        held_prev  = 1'b0;
        stall_sent = 1'b0;
        n0 = $urandom_range(60, 30);
        n1 = $urandom_range(60, 30);
        cycle_limit = (n0 + n1 + 2 * (`QUEUE_SIZE + 2)) * per_request_cycles + stall_cycles + 100;
        repeat (10) @(posedge clk_in);
        #1;
        reset_in = 1'b0;
        repeat (5)
        begin
            next_cycle();
            assert (!out_valid && !req0_ack && !req1_ack)
            else stop_with_failure("A control output went high before any request.");
        end

        fork
            send_words(0, n0, 6);
            send_words(1, n1, 6);
        join
        wait_drained();
        check_idle(10);

        ack_mode = 1;  // downstream stalls so both queues fill up.
        fork
            begin
                fork
                    send_words(0, `QUEUE_SIZE + 2, 0);
                    send_words(1, `QUEUE_SIZE + 2, 0);
                join
                stall_sent = 1'b1;
            end
        join_none
        repeat (stall_cycles) next_cycle();
        assert (expected0.size() == `QUEUE_SIZE)
        else mismatch_error("queue 0 depth", 64'(expected0.size()), 64'(`QUEUE_SIZE));
        assert (expected1.size() == `QUEUE_SIZE)
        else mismatch_error("queue 1 depth", 64'(expected1.size()), 64'(`QUEUE_SIZE));
        repeat (5)
        begin
            next_cycle();
            assert (!req0_ack && !req1_ack)
            else stop_with_failure("A requester got an ack while its queue was full.");
        end
        served_any = 1'b0;
        fair_check = 1'b1;
        ack_mode   = 2;
        while (!stall_sent)
        begin
            next_cycle();
        end
        wait_drained();
        check_idle(10);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: project.f
+incdir+include
hdl/request_pkg.sv
hdl/arbiter_pkg.sv
hdl/dual_port_lutram.sv
hdl/fifo_queue.sv
hdl/request_arbiter.sv
hdl/request_merge_top.sv
testbench/tb_request_merge.sv

// File: Makefile
TOP = tb_request_merge

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "Simulation finished: PASS"

clean:
	rm -rf obj_dir
